//--- source/icache_pkg.sv
package icache_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////
  localparam int DATA_WIDTH   = 128;                        // one block
  localparam int BLOCK_BYTES  = DATA_WIDTH / 8;             // 16
  localparam int ADDR_W       = 16;                         // 64 KB memory
  localparam int OFFSET_W     = $clog2(BLOCK_BYTES);        // 4 bits
  localparam int CACHE_DEPTH  = 64;                         // 1 KB cache
  localparam int INDEX_W      = $clog2(CACHE_DEPTH);        // 6 bits
  localparam int TAG_W        = ADDR_W - INDEX_W - OFFSET_W; // 6 bits
  localparam int BLOCK_ADDR_W = TAG_W + INDEX_W;            // memory address width

  // a 32-bit instruction at this offset or above spills into the next block
  localparam logic [OFFSET_W-1:0] MISALIGN_OFFSET = OFFSET_W'(BLOCK_BYTES - 3);

  //////////////////////////////////////////////////
  // address views
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } icache_fields_t;

  typedef struct packed {
    logic [BLOCK_ADDR_W-1:0] block_addr; // tag and index together
    logic [OFFSET_W-1:0]     offset;
  } icache_block_t;

  typedef union packed {
    icache_fields_t fields; // for the arrays
    icache_block_t  block;  // for the memory side
  } icache_addr_u;

  // miss controller outputs
  typedef struct packed {
    logic cache_wren;
    logic set_valid;
    logic replace_tag;
    logic addr_sel;          // 0 current block, 1 next block
    logic set_valid_align;
    logic replace_tag_align;
  } icache_ctrl_t;

  typedef enum logic [1:0] {
    S_COMPARE,
    S_FILL,
    S_FILL_ALIGN
  } icache_state_e;

endpackage

//--- source/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  icache_pkg::icache_addr_u i_addr,
  input  icache_pkg::icache_ctrl_t i_ctrl,
  output logic                     o_hit,
  output logic                     o_hit_align
);

  logic [icache_pkg::TAG_W-1:0]        tags [icache_pkg::CACHE_DEPTH];
  logic [icache_pkg::CACHE_DEPTH-1:0]  valid;

  logic [icache_pkg::BLOCK_ADDR_W-1:0] next_block;
  logic [icache_pkg::TAG_W-1:0]        next_tag;
  logic [icache_pkg::INDEX_W-1:0]      next_index;

  // following block, index overflow carries into the tag
  assign next_block             = i_addr.block.block_addr + 1'b1;
  assign {next_tag, next_index} = next_block;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////
  assign o_hit = valid[i_addr.fields.index] &&
                 (tags[i_addr.fields.index] == i_addr.fields.tag);

  assign o_hit_align = valid[next_index] && (tags[next_index] == next_tag);

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      valid <= '0; // whole cache empty
    end else begin
      if (i_ctrl.set_valid) begin
        valid[i_addr.fields.index] <= 1'b1;
      end
      if (i_ctrl.set_valid_align) begin
        valid[next_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ctrl.replace_tag) begin
      tags[i_addr.fields.index] <= i_addr.fields.tag;
    end
    if (i_ctrl.replace_tag_align) begin
      tags[next_index] <= next_tag; // may differ from current tag at last index
    end
  end

endmodule

//--- source/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array (
  input  logic                                i_clk,
  input  logic                                i_wren,
  input  icache_pkg::icache_addr_u            i_addr,
  input  logic                                i_addr_sel,
  input  logic [icache_pkg::DATA_WIDTH-1:0]   i_data,
  output logic [icache_pkg::DATA_WIDTH-1:0]   o_data,
  output logic [icache_pkg::DATA_WIDTH-1:0]   o_data_align
);

  logic [icache_pkg::DATA_WIDTH-1:0] mem [icache_pkg::CACHE_DEPTH];

  logic [icache_pkg::INDEX_W-1:0] next_index;
  logic [icache_pkg::INDEX_W-1:0] wr_index;

  assign next_index = i_addr.fields.index + 1'b1; // wraps at the last line
  assign wr_index   = i_addr_sel ? next_index : i_addr.fields.index;

  // both lines read asynchronously
  assign o_data       = mem[i_addr.fields.index];
  assign o_data_align = mem[next_index];

  //////////////////////////////////////////////////
  // fill port
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_wren) begin
      mem[wr_index] <= i_data;
    end
  end

endmodule

//--- source/icache_fsm.sv
`timescale 1ns/1ps

module icache_fsm (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_hit,
  input  logic                              i_hit_align,
  input  logic [icache_pkg::OFFSET_W-1:0]   i_offset,
  input  logic                              i_mem_ready,
  output icache_pkg::icache_ctrl_t          o_ctrl,
  output logic                              o_mem_rden,
  output logic                              o_stall
);

  icache_pkg::icache_state_e state;
  icache_pkg::icache_state_e state_next;

  logic misaligned;
  logic align_miss;

  // instruction runs into the following block
  assign misaligned = (i_offset >= icache_pkg::MISALIGN_OFFSET);
  assign align_miss = misaligned && !i_hit_align;

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= icache_pkg::S_COMPARE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    o_ctrl     = '0;
    o_mem_rden = 1'b0;
    o_stall    = 1'b1;

    case (state)
      icache_pkg::S_COMPARE: begin
        o_stall = !i_hit || align_miss;
        if (!i_hit) begin
          state_next = icache_pkg::S_FILL;       // primary block first
        end else if (align_miss) begin
          state_next = icache_pkg::S_FILL_ALIGN;
        end
      end

      icache_pkg::S_FILL: begin
        o_mem_rden = 1'b1;
        if (i_mem_ready) begin
          o_ctrl.cache_wren  = 1'b1;
          o_ctrl.set_valid   = 1'b1;
          o_ctrl.replace_tag = 1'b1;
          state_next         = icache_pkg::S_COMPARE; // recheck the second block there
        end
      end

      icache_pkg::S_FILL_ALIGN: begin
        o_mem_rden      = 1'b1;
        o_ctrl.addr_sel = 1'b1; // memory and write both on next block
        if (i_mem_ready) begin
          o_ctrl.cache_wren        = 1'b1;
          o_ctrl.set_valid_align   = 1'b1;
          o_ctrl.replace_tag_align = 1'b1;
          state_next               = icache_pkg::S_COMPARE;
        end
      end

      default: begin
        state_next = icache_pkg::S_COMPARE;
      end
    endcase
  end

endmodule

//--- source/icache_instr_align.sv
`timescale 1ns/1ps

module icache_instr_align (
  input  logic [icache_pkg::DATA_WIDTH-1:0] i_block,
  input  logic [icache_pkg::DATA_WIDTH-1:0] i_block_next,
  input  logic [icache_pkg::OFFSET_W-1:0]   i_offset,
  output logic [31:0]                       o_instr
);

  // two blocks side by side, next block above current one
  logic [2*icache_pkg::DATA_WIDTH-1:0] window;
  logic [icache_pkg::OFFSET_W+2:0]     bit_pos;

  assign window  = {i_block_next, i_block};
  assign bit_pos = {i_offset, 3'b000}; // byte offset to bit offset

  // little endian, lowest byte at the offset
  // offsets 13..15 pull their upper bytes from the next block
  assign o_instr = window[bit_pos +: 32];

endmodule

//--- source/riscv_instructions_cache.sv
`timescale 1ns/1ps

module riscv_instructions_cache (
  input  logic                                  i_riscv_icache_clk,
  input  logic                                  i_reset,
  input  logic [63:0]                           i_phys_addr,
  input  logic                                  i_mem_ready,
  input  logic [icache_pkg::DATA_WIDTH-1:0]     i_mem_data,
  output logic [icache_pkg::BLOCK_ADDR_W-1:0]   o_mem_addr,
  output logic                                  o_mem_rden,
  output logic [31:0]                           o_cpu_instr,
  output logic                                  o_cpu_stall
);

  icache_pkg::icache_addr_u            addr;
  icache_pkg::icache_ctrl_t            ctrl;
  logic [icache_pkg::BLOCK_ADDR_W-1:0] next_block;
  logic                                hit;
  logic                                hit_align;
  logic [icache_pkg::DATA_WIDTH-1:0]   block;
  logic [icache_pkg::DATA_WIDTH-1:0]   block_next;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  assign addr       = i_phys_addr[icache_pkg::ADDR_W-1:0]; // upper bits unused
  assign next_block = addr.block.block_addr + 1'b1;
  assign o_mem_addr = ctrl.addr_sel ? next_block : addr.block.block_addr;

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////
  icache_tag_array u_tag_array (
    .i_clk       (i_riscv_icache_clk),
    .i_reset     (i_reset           ),
    .i_addr      (addr              ),
    .i_ctrl      (ctrl              ),
    .o_hit       (hit               ),
    .o_hit_align (hit_align         )
  );

  icache_data_array u_data_array (
    .i_clk        (i_riscv_icache_clk),
    .i_wren       (ctrl.cache_wren   ),
    .i_addr       (addr              ),
    .i_addr_sel   (ctrl.addr_sel     ), // same select as the memory address
    .i_data       (i_mem_data        ),
    .o_data       (block             ),
    .o_data_align (block_next        )
  );

  icache_fsm u_fsm (
    .i_clk       (i_riscv_icache_clk ),
    .i_reset     (i_reset            ),
    .i_hit       (hit                ),
    .i_hit_align (hit_align          ),
    .i_offset    (addr.fields.offset ),
    .i_mem_ready (i_mem_ready        ),
    .o_ctrl      (ctrl               ),
    .o_mem_rden  (o_mem_rden         ),
    .o_stall     (o_cpu_stall        )
  );

  icache_instr_align u_instr_align (
    .i_block      (block             ),
    .i_block_next (block_next        ),
    .i_offset     (addr.fields.offset),
    .o_instr      (o_cpu_instr       )
  );

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  localparam int MAX_TESTS = 64;
  localparam int COLS      = 4; // reset, addr, reads, instr

  logic                                clk;
  logic                                i_reset;
  logic [63:0]                         i_phys_addr;
  logic                                i_mem_ready = 1'b0;
  logic [icache_pkg::DATA_WIDTH-1:0]   i_mem_data  = '0;
  logic [icache_pkg::BLOCK_ADDR_W-1:0] o_mem_addr;
  logic                                o_mem_rden;
  logic [31:0]                         o_cpu_instr;
  logic                                o_cpu_stall;

  logic [31:0] test_mem [MAX_TESTS*COLS];
  int          num_tests;
  int          cycle_limit   = 0;
  int          cycles        = 0;
  int          reads_total   = 0;
  logic        rden_seen     = 1'b0;
  logic        mem_busy      = 1'b0;
  int          mem_delay     = 0;
  int          tests_failed  = 0;
  int          checks_failed = 0;

  logic [icache_pkg::BLOCK_ADDR_W-1:0] fill_addrs [$]; // block addresses of this test's fills

  riscv_instructions_cache u_dut (
    .i_riscv_icache_clk (clk        ),
    .i_reset            (i_reset    ),
    .i_phys_addr        (i_phys_addr),
    .i_mem_ready        (i_mem_ready),
    .i_mem_data         (i_mem_data ),
    .o_mem_addr         (o_mem_addr ),
    .o_mem_rden         (o_mem_rden ),
    .o_cpu_instr        (o_cpu_instr),
    .o_cpu_stall        (o_cpu_stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // memory contents
  //////////////////////////////////////////////////
  function automatic logic [7:0] mem_byte(input logic [15:0] b);
    logic [7:0] prod;
    prod = 8'(b * 16'd3); // only the low byte matters
    return prod ^ 8'h5a;
  endfunction

  function automatic logic [icache_pkg::DATA_WIDTH-1:0] block_data(
    input logic [icache_pkg::BLOCK_ADDR_W-1:0] block_addr
  );
    logic [icache_pkg::DATA_WIDTH-1:0] data;
    data = '0;
    for (int k = 0; k < icache_pkg::BLOCK_BYTES; k++) begin
      data[8*k +: 8] = mem_byte({block_addr, 4'(k)}); // byte 0 lowest
    end
    return data;
  endfunction

  // four bytes from the address up, wrapping at 64 KB
  function automatic logic [31:0] expected_instr(input logic [15:0] addr);
    return {mem_byte(addr + 16'd3), mem_byte(addr + 16'd2),
            mem_byte(addr + 16'd1), mem_byte(addr)};
  endfunction

  //////////////////////////////////////////////////
  // memory model and read counter
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (i_mem_ready) begin
      i_mem_ready <= 1'b0; // one-cycle pulse
      mem_busy    <= 1'b0;
    end else if (o_mem_rden) begin
      if (!mem_busy) begin
        mem_busy  <= 1'b1;
        mem_delay <= int'($urandom_range(4, 1));
      end else if (mem_delay > 1) begin
        mem_delay <= mem_delay - 1;
      end else begin
        i_mem_ready <= 1'b1;
        i_mem_data  <= block_data(o_mem_addr);
      end
    end
  end

  always @(negedge clk) begin
    if (o_mem_rden && !rden_seen) begin
      reads_total <= reads_total + 1; // one per fill request
      fill_addrs.push_back(o_mem_addr);
    end
    rden_seen <= o_mem_rden;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never released stall", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // one fetch from the test file
  //////////////////////////////////////////////////
  task automatic run_test(input int t);
    logic [15:0]                         addr;
    int                                  exp_reads;
    logic [31:0]                         exp_instr;
    int                                  reads_start;
    int                                  reads;
    int                                  fails_start;
    logic [icache_pkg::BLOCK_ADDR_W-1:0] cur_block;
    logic [icache_pkg::BLOCK_ADDR_W-1:0] nxt_block;
    addr        = test_mem[t*COLS+1][15:0];
    exp_reads   = int'(test_mem[t*COLS+2]);
    exp_instr   = test_mem[t*COLS+3];
    cur_block   = addr[15:4];
    nxt_block   = cur_block + 1'b1; // carries from index into tag
    fails_start = checks_failed;
    @(negedge clk);
    i_phys_addr = {48'd0, addr};
    if (test_mem[t*COLS] == 32'd1) begin
      i_reset = 1'b1; // new address is already in place
      repeat (8) @(negedge clk);
    end
    i_reset     = 1'b0;
    reads_start = reads_total;
    fill_addrs.delete();
    @(negedge clk);
    while (o_cpu_stall) @(negedge clk);
    reads = reads_total - reads_start;
    assert (o_cpu_instr == exp_instr) else begin
      $display("FAILED test %0d o_cpu_instr = %h, file expects %h", t, o_cpu_instr, exp_instr);
      checks_failed++;
    end
    assert (o_cpu_instr == expected_instr(addr)) else begin
      $display("FAILED test %0d o_cpu_instr = %h, memory bytes give %h", t, o_cpu_instr,
               expected_instr(addr));
      checks_failed++;
    end
    assert (reads == exp_reads) else begin
      $display("FAILED test %0d o_mem_rden reads = %h, expected %h", t, reads, exp_reads);
      checks_failed++;
    end
    // primary block is fetched first, the following block second
    if (fill_addrs.size() == 2) begin
      assert (fill_addrs[0] == cur_block && fill_addrs[1] == nxt_block) else begin
        $display("FAILED test %0d o_mem_addr = %h then %h, expected %h then %h", t,
                 fill_addrs[0], fill_addrs[1], cur_block, nxt_block);
        checks_failed++;
      end
    end else if (fill_addrs.size() == 1) begin
      assert (fill_addrs[0] == cur_block ||
              (addr[3:0] >= 4'd13 && fill_addrs[0] == nxt_block)) else begin
        $display("FAILED test %0d o_mem_addr = %h, expected %h or %h", t,
                 fill_addrs[0], cur_block, nxt_block);
        checks_failed++;
      end
    end
    if (checks_failed != fails_start) begin
      tests_failed++;
    end
    $display("test %0d addr %h reads %0d instr %h %s", t, addr, reads, o_cpu_instr,
             (checks_failed == fails_start) ? "pass" : "fail");
  endtask

  initial begin
    void'($urandom(32'hfb799cd6));
    i_reset     = 1'b1;
    i_phys_addr = '0;
    for (int i = 0; i < MAX_TESTS*COLS; i++) begin
      test_mem[i] = '1; // rows past the file end
    end
    $readmemh("verification/icache_tests.txt", test_mem);
    num_tests = 0;
    while (num_tests < MAX_TESTS && test_mem[num_tests*COLS] <= 32'd1) begin
      num_tests++;
    end
    cycle_limit = num_tests * 20 + 200;
    if (num_tests == 0) begin
      $display("no tests were found in verification/icache_tests.txt");
      checks_failed++;
    end
    repeat (8) @(negedge clk); // first test releases reset
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d", num_tests, num_tests - tests_failed,
             tests_failed);
    if (checks_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verification/icache_tests.txt
// columns in hex: reset flag, address, memory reads expected, instruction expected
// memory byte b holds ((b * 3) xor 5a), low 8 bits
1 0100 1 535c595a
0 0100 0 535c595a
0 0101 0 56535c59
0 0102 0 5556535c
0 0103 0 48555653
0 0104 0 4f485556
0 0105 0 424f4855
0 0106 0 41424f48
0 0107 0 4441424f
0 0108 0 7b444142
0 0109 0 7e7b4441
0 010a 0 7d7e7b44
0 010b 0 707d7e7b
0 010c 0 77707d7e
0 010e 1 696a7770
0 0a2d 2 cad7d0dd
0 0b3e 2 999ae7e0
0 17ff 2 5c595aa7
0 17ff 0 5c595aa7
0 4100 1 535c595a
0 0100 1 535c595a
1 0105 1 424f4855

//--- riscv_icache.f
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_fsm.sv
source/icache_instr_align.sv
source/riscv_instructions_cache.sv
verification/icache_tb.sv

//--- run_riscv_icache.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.
# Run from anywhere; paths are taken relative to this script.

cd "$(dirname "$0")" || exit 1

LOG=sim_riscv_icache.log
OBJ=obj_dir

verilator --binary --timing --assert -f riscv_icache.f \
  --top-module icache_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vicache_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
